/* logic/inv_sqrt_pkg.sv */
//====================
// shared Q5.10 definitions for the inverse square root pipeline
// every RTL file refers to these by scoped name
//====================
package inv_sqrt_pkg;

    //====================
    // word format
    //====================

    // width of every data word in the pipeline
    parameter int word_w = 16;

    // fraction bits of Q5.10
    parameter int frac_bits = 10;

    // 3.0 in Q5.10, minuend of the correction term
    parameter logic signed [word_w-1:0] q_three = 16'sh0C00;

    //====================
    // variance decoding
    //====================

    // one variance word seen two ways
    // raw feeds the multipliers, fields feeds the seed table
    typedef union packed {
        logic signed [word_w-1:0] raw;
        struct packed {
            // integer bits, sign bit on top
            logic [word_w-frac_bits-1:0] int_part;
            logic [frac_bits-1:0]        frac_part;
        } fields;
    } variance_u;

endpackage

/* logic/seed_lookup.sv */
//====================
// entry stage of the inverse square root pipeline
// registers the input item and picks the starting guess from a table
//====================
`timescale 1ns/1ns

module seed_lookup (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   valid_in,
    input  logic signed [inv_sqrt_pkg::word_w-1:0] variance_in,
    input  logic signed [inv_sqrt_pkg::word_w-1:0] mean_in,
    output logic                                   valid_out,
    output logic signed [inv_sqrt_pkg::word_w-1:0] variance_out,
    output logic signed [inv_sqrt_pkg::word_w-1:0] guess_out,
    output logic signed [inv_sqrt_pkg::word_w-1:0] mean_out
);

    inv_sqrt_pkg::variance_u                var_view;
    logic signed [inv_sqrt_pkg::word_w-1:0] seed;

    assign var_view.raw = variance_in;

    // coarse 1/sqrt guess, one step per power of two of the integer part
    always_comb begin
        casez (var_view.fields.int_part)
            6'b000000: seed = 16'h8000;
            6'b000001: seed = 16'h4000;
            6'b00001?: seed = 16'h2000;
            6'b0001??: seed = 16'h1000;
            6'b001???: seed = 16'h0800;
            6'b01????: seed = 16'h0600;
            // negative variance lands here too
            default:   seed = 16'h0400;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // payload loads only with a valid item
    always_ff @(posedge clk) begin
        if (valid_in) begin
            variance_out <= variance_in;
            guess_out    <= seed;
            mean_out     <= mean_in;
        end
    end

endmodule

/* logic/newton_step.sv */
//====================
// one Newton-Raphson refinement of 1/sqrt(v), four register stages
// x_next = x * (3 - v * x * x) / 2, chained once per iteration
//====================
`timescale 1ns/1ns

module newton_step (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   valid_in,
    input  logic signed [inv_sqrt_pkg::word_w-1:0] variance_in,
    input  logic signed [inv_sqrt_pkg::word_w-1:0] guess_in,
    input  logic signed [inv_sqrt_pkg::word_w-1:0] mean_in,
    output logic                                   valid_out,
    output logic signed [inv_sqrt_pkg::word_w-1:0] variance_out,
    output logic signed [inv_sqrt_pkg::word_w-1:0] guess_out,
    output logic signed [inv_sqrt_pkg::word_w-1:0] mean_out
);

    localparam int w = inv_sqrt_pkg::word_w;
    localparam int f = inv_sqrt_pkg::frac_bits;

    //====================
    // per-stage state
    //====================

    // stage 1: x squared
    logic              s1_valid;
    logic signed [w-1:0] s1_var;
    logic signed [w-1:0] s1_guess;
    logic signed [w-1:0] s1_mean;
    logic signed [w-1:0] s1_sq;

    // stage 2: v * x^2
    logic              s2_valid;
    logic signed [w-1:0] s2_var;
    logic signed [w-1:0] s2_guess;
    logic signed [w-1:0] s2_mean;
    logic signed [w-1:0] s2_scaled;

    // stage 3: 3 - v * x^2
    logic              s3_valid;
    logic signed [w-1:0] s3_var;
    logic signed [w-1:0] s3_guess;
    logic signed [w-1:0] s3_mean;
    logic signed [w-1:0] s3_corr;

    // full 32-bit products
    logic signed [2*w-1:0] sq_full;
    logic signed [2*w-1:0] scaled_full;
    logic signed [2*w-1:0] next_full;

    assign sq_full     = guess_in * guess_in;
    assign scaled_full = s1_var * s1_sq;
    // extra bit of shift below gives the divide by two
    assign next_full   = s3_guess * s3_corr;

    //====================
    // valid pipeline
    //====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            s1_valid  <= valid_in;
            s2_valid  <= s1_valid;
            s3_valid  <= s2_valid;
            valid_out <= s3_valid;
        end
    end

    //====================
    // data pipeline
    //====================

    // each item keeps its own variance, guess and mean copy per stage
    always_ff @(posedge clk) begin
        if (valid_in) begin
            s1_var   <= variance_in;
            s1_guess <= guess_in;
            s1_mean  <= mean_in;
            s1_sq    <= sq_full[f +: w];
        end

        if (s1_valid) begin
            s2_var    <= s1_var;
            s2_guess  <= s1_guess;
            s2_mean   <= s1_mean;
            s2_scaled <= scaled_full[f +: w];
        end

        // wraps at 16 bits
        if (s2_valid) begin
            s3_var   <= s2_var;
            s3_guess <= s2_guess;
            s3_mean  <= s2_mean;
            s3_corr  <= inv_sqrt_pkg::q_three - s2_scaled;
        end

        if (s3_valid) begin
            variance_out <= s3_var;
            mean_out     <= s3_mean;
            guess_out    <= next_full[f+1 +: w];
        end
    end

endmodule

/* logic/inv_sqrt_top.sv */
//====================
// pipelined 1/sigma from a Q5.10 variance, mean travels alongside
// latency 1 + 4 * num_iter cycles, one item accepted per cycle
//====================
`timescale 1ns/1ns

module inv_sqrt_top #(
    parameter int num_iter = 3
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   valid_in,
    input  logic signed [inv_sqrt_pkg::word_w-1:0] variance_in,
    input  logic signed [inv_sqrt_pkg::word_w-1:0] mean_in,
    output logic                                   valid_out,
    output logic signed [inv_sqrt_pkg::word_w-1:0] inv_sigma_out,
    output logic signed [inv_sqrt_pkg::word_w-1:0] mean_out
);

    // slot 0 comes from the seed stage, slot k+1 from iteration k
    logic                                   valid_chain [0:num_iter];
    logic signed [inv_sqrt_pkg::word_w-1:0] var_chain   [0:num_iter];
    logic signed [inv_sqrt_pkg::word_w-1:0] guess_chain [0:num_iter];
    logic signed [inv_sqrt_pkg::word_w-1:0] mean_chain  [0:num_iter];

    seed_lookup i_seed (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .variance_in  (variance_in),
        .mean_in      (mean_in),
        .valid_out    (valid_chain[0]),
        .variance_out (var_chain[0]),
        .guess_out    (guess_chain[0]),
        .mean_out     (mean_chain[0])
    );

    //====================
    // Newton iterations
    //====================
    generate
        for (genvar k = 0; k < num_iter; k++) begin : g_iter
            newton_step i_step (
                .clk          (clk),
                .rst_n        (rst_n),
                .valid_in     (valid_chain[k]),
                .variance_in  (var_chain[k]),
                .guess_in     (guess_chain[k]),
                .mean_in      (mean_chain[k]),
                .valid_out    (valid_chain[k+1]),
                // the last slot has no consumer for its variance
                .variance_out (var_chain[k+1]),
                .guess_out    (guess_chain[k+1]),
                .mean_out     (mean_chain[k+1])
            );
        end
    endgenerate

    assign valid_out     = valid_chain[num_iter];
    assign inv_sigma_out = guess_chain[num_iter];
    assign mean_out      = mean_chain[num_iter];

endmodule

/* testbench/tb_inv_sqrt.sv */
//====================
// self-checking testbench for the inverse square root pipeline
// reads vectors from the stimulus file, checks result, mean and latency
//====================
`timescale 1ns/1ns

module tb_inv_sqrt;

    logic        clk;
    logic        rst_n;
    logic        valid_in;
    logic [15:0] variance_in;
    logic [15:0] mean_in;
    logic        valid_out;
    logic [15:0] inv_sigma_out;
    logic [15:0] mean_out;

    // vectors loaded from the stimulus file
    int          gap_tab [$];
    logic [15:0] var_tab [$];
    logic [15:0] mean_tab [$];
    logic [15:0] exp_tab [$];

    // items in flight, front is the oldest
    logic [15:0] exp_inv_q [$];
    logic [15:0] exp_mean_q [$];
    int          due_q [$];

    int          cycle;
    int          cycle_limit;
    logic [31:0] lcg_state;

    inv_sqrt_top #(
        .num_iter (3)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .variance_in   (variance_in),
        .mean_in       (mean_in),
        .valid_out     (valid_out),
        .inv_sigma_out (inv_sigma_out),
        .mean_out      (mean_out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //====================
    // helpers
    //====================
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, expected);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic load_vectors;
        int    fd;
        int    n;
        int    gap;
        int    v;
        int    m;
        int    e;
        string line;
        fd = $fopen("testbench/inv_sqrt_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("TB FAILED");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // comment lines do not parse as hex and are skipped
            n = $sscanf(line, "%h %h %h %h", gap, v, m, e);
            if (n == 4) begin
                gap_tab.push_back(gap);
                var_tab.push_back(v[15:0]);
                mean_tab.push_back(m[15:0]);
                exp_tab.push_back(e[15:0]);
            end
        end
        $fclose(fd);
    endtask

    //====================
    // stimulus
    //====================
    initial begin
        int idle;
        clk         = 1'b0;
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        variance_in = '0;
        mean_in     = '0;
        cycle       = 0;
        lcg_state   = 32'h160bcfba;

        load_vectors();
        if (var_tab.size() == 0) begin
            $display("the stimulus file holds no vectors");
            $display("TB FAILED");
            $fatal(1, "empty stimulus");
        end
        cycle_limit = var_tab.size() * 4 + 13 + 20;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        check_value(valid_out, 0, "valid_out during reset");

        for (int i = 0; i < var_tab.size(); i++) begin
            // nonzero column is idle cycles plus one, zero asks for a random gap
            if (gap_tab[i] != 0) begin
                idle = gap_tab[i] - 1;
            end else begin
                lcg_state = lcg_next(lcg_state);
                idle = lcg_state[17:16];
            end
            repeat (idle) begin
                @(posedge clk);
                valid_in <= 1'b0;
            end
            @(posedge clk);
            valid_in    <= 1'b1;
            variance_in <= var_tab[i];
            mean_in     <= mean_tab[i];
            exp_inv_q.push_back(exp_tab[i]);
            exp_mean_q.push_back(mean_tab[i]);
            // driven at this edge, seed plus twelve step registers follow
            due_q.push_back(cycle + 1 + 13);
        end
        @(posedge clk);
        valid_in <= 1'b0;

        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);

        $display("TB PASSED");
        $finish;
    end

    //====================
    // output monitor
    //====================

    // sampled mid-cycle where outputs are stable
    always @(negedge clk) begin
        if (valid_out) begin
            if (due_q.size() == 0) begin
                $display("valid_out rose with no item in flight at %0t ns", $time);
                $display("TB FAILED");
                $fatal(1, "unexpected output");
            end else begin
                check_value(cycle, due_q.pop_front(), "latency");
                check_value(inv_sigma_out, exp_inv_q.pop_front(), "inv_sigma_out");
                check_value(mean_out, exp_mean_q.pop_front(), "mean_out");
            end
        end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
            $display("expected output missing at cycle %0d", cycle);
            $display("TB FAILED");
            $fatal(1, "missing output");
        end
    end

    always @(posedge clk) begin
        if (cycle_limit != 0 && cycle > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

/* testbench/inv_sqrt_stimulus.txt */
# columns: gap variance mean expected_inv_sigma, all hex
# gap 0 = random 0-3 idle cycles, gap n = n-1 idle cycles (1 = back-to-back)
0 0400 0011 D800
0 0100 0022 9000
2 0001 0033 9000
1 0800 0044 4C00
1 1000 0055 CE00
1 2000 0066 1100
1 4000 0077 A100
1 7FFF 0088 BF24
1 FC00 0099 5800
1 07FF 00AA 5720
4 0200 00BB 9000
0 1000 F001 CE00
0 2000 F002 1100
3 4000 F003 A100
0 FC00 F004 5800
1 0400 1234 D800
1 0400 5678 D800
1 0400 9ABC D800
1 0400 DEF0 D800
0 07FF 0F0F 5720
0 7FFF 7FFF BF24
1 0800 8000 4C00
1 0100 FFFF 9000
1 FC00 0001 5800
2 2000 2222 1100
0 0001 3333 9000

/* tb.f */
logic/inv_sqrt_pkg.sv
logic/seed_lookup.sv
logic/newton_step.sv
logic/inv_sqrt_top.sv
testbench/tb_inv_sqrt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the inverse square root testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing -Wno-fatal \
    --top-module tb_inv_sqrt \
    -f tb.f \
    -o sim_inv_sqrt

# exit status of the simulation is the result
./obj_dir/sim_inv_sqrt
